// ==== compile.f ====
exu_pkg.sv
exu_alu.sv
exu_lsu.sv
data_sram.sv
exu_stage.sv
wb_fifo.sv
exu_top.sv
tb_exu_top.sv

// ==== data_sram.sv ====
`timescale 1ns/1ps

module data_sram import exu_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic      clk,
  input  logic      i_rst_n,
  input  axil_req_t i_axi,
  output axil_rsp_t o_axi
);

  localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

  logic [XLEN-1:0]   mem [MEM_WORDS];
  logic              aw_got;
  logic              w_got;
  logic              bvalid;
  logic              rvalid;
  logic [AW-1:0]     awidx_q;
  logic [XLEN-1:0]   wdata_q;
  logic [XLEN/8-1:0] wstrb_q;
  logic [XLEN-1:0]   rdata_q;
  logic              aw_fire;
  logic              w_fire;
  logic              ar_fire;
  logic              wr_en;
  logic [AW-1:0]     wr_idx;
  logic [XLEN-1:0]   wr_data;
  logic [XLEN/8-1:0] wr_strb;

  assign o_axi.awready = !aw_got && !bvalid && !rvalid;
  assign o_axi.wready  = !w_got && !bvalid && !rvalid;
  assign o_axi.arready = !aw_got && !w_got && !bvalid && !rvalid;
  assign o_axi.bresp   = 2'b00;
  assign o_axi.bvalid  = bvalid;
  assign o_axi.rdata   = rdata_q;
  assign o_axi.rresp   = 2'b00;
  assign o_axi.rvalid  = rvalid;

  assign aw_fire = i_axi.awvalid && o_axi.awready;
  assign w_fire  = i_axi.wvalid && o_axi.wready;
  assign ar_fire = i_axi.arvalid && o_axi.arready;

  // write once both halves are in, either held or arriving now
  assign wr_en   = (aw_got || aw_fire) && (w_got || w_fire);
  assign wr_idx  = aw_fire ? i_axi.awaddr[2 +: AW] : awidx_q;
  assign wr_data = w_fire ? i_axi.wdata : wdata_q;
  assign wr_strb = w_fire ? i_axi.wstrb : wstrb_q;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      aw_got <= 1'b0;
      w_got  <= 1'b0;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      if (wr_en) begin
        aw_got <= 1'b0;
        w_got  <= 1'b0;
        bvalid <= 1'b1;
      end else begin
        aw_got <= aw_got || aw_fire;
        w_got  <= w_got || w_fire;
      end
      if (bvalid && i_axi.bready) begin
        bvalid <= 1'b0;
      end
      if (ar_fire) begin
        rvalid <= 1'b1;
      end else if (rvalid && i_axi.rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      awidx_q <= i_axi.awaddr[2 +: AW];
    end
    if (w_fire) begin
      wdata_q <= i_axi.wdata;
      wstrb_q <= i_axi.wstrb;
    end
    if (wr_en) begin
      for (int b = 0; b < XLEN/8; b++) begin
        if (wr_strb[b]) begin
          mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
    if (ar_fire) begin
      rdata_q <= mem[i_axi.araddr[2 +: AW]];
    end
  end

endmodule

// ==== exu_alu.sv ====
`timescale 1ns/1ps

module exu_alu import exu_pkg::*; (
  input  logic [XLEN-1:0] i_a,
  input  logic [XLEN-1:0] i_b,
  input  alu_op_e         i_op,
  output logic [XLEN-1:0] o_res,
  output logic            o_eq,
  output logic            o_lt,
  output logic            o_ltu
);

  logic [4:0] shamt;

  assign shamt = i_b[4:0];

  // compare flags, shared by slt and the branches
  assign o_eq  = (i_a == i_b);
  assign o_lt  = ($signed(i_a) < $signed(i_b));
  assign o_ltu = (i_a < i_b);

  always_comb begin
    case (i_op)
      ALU_ADD: begin
        o_res = i_a + i_b;
      end
      ALU_SUB: begin
        o_res = i_a - i_b;
      end
      ALU_AND: begin
        o_res = i_a & i_b;
      end
      ALU_OR: begin
        o_res = i_a | i_b;
      end
      ALU_XOR: begin
        o_res = i_a ^ i_b;
      end
      ALU_SLL: begin
        o_res = i_a << shamt;
      end
      ALU_SRL: begin
        o_res = i_a >> shamt;
      end
      ALU_SRA: begin
        o_res = $signed(i_a) >>> shamt;
      end
      ALU_SLT: begin
        o_res = {{(XLEN-1){1'b0}}, o_lt};
      end
      ALU_SLTU: begin
        o_res = {{(XLEN-1){1'b0}}, o_ltu};
      end
      default: begin
        o_res = '0;
      end
    endcase
  end

endmodule

// ==== exu_lsu.sv ====
`timescale 1ns/1ps

module exu_lsu import exu_pkg::*; (
  input  logic            clk,
  input  logic            i_rst_n,
  input  logic            i_start,
  input  logic [XLEN-1:0] i_addr,
  input  logic [XLEN-1:0] i_wdata,
  input  mem_op_e         i_mem_op,
  output logic            o_done,
  output logic [XLEN-1:0] o_rdata,
  output axil_req_t       o_axi,
  input  axil_rsp_t       i_axi
);

  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    WRESP,
    READ,
    RDATA
  } lsu_state_e;

  lsu_state_e        state;
  logic              aw_valid;
  logic              w_valid;
  logic              b_ready;
  logic              ar_valid;
  logic              r_ready;
  logic              done;
  logic [XLEN-1:0]   addr_q;
  mem_op_e           op_q;
  logic [XLEN-1:0]   wdata_q;
  logic [XLEN/8-1:0] wstrb_q;
  logic [XLEN-1:0]   rdata_q;
  logic              start_store;
  logic [XLEN-1:0]   st_data;
  logic [XLEN/8-1:0] st_strb;
  logic [XLEN-1:0]   byte_sel;
  logic [XLEN-1:0]   half_sel;
  logic [XLEN-1:0]   load_ext;

  assign start_store = i_mem_op inside {MEM_SB, MEM_SH, MEM_SW};

  // replicate into every lane, the strobe picks the one that counts
  always_comb begin
    case (i_mem_op)
      MEM_SB: begin
        st_data = {4{i_wdata[7:0]}};
        st_strb = 4'b0001 << i_addr[1:0];
      end
      MEM_SH: begin
        st_data = {2{i_wdata[15:0]}};
        st_strb = 4'b0011 << {i_addr[1], 1'b0};
      end
      default: begin
        st_data = i_wdata;
        st_strb = 4'b1111;
      end
    endcase
  end

  always_comb begin
    byte_sel = i_axi.rdata >> {addr_q[1:0], 3'b000};
    half_sel = i_axi.rdata >> {addr_q[1], 4'b0000};
    case (op_q)
      MEM_LB:  load_ext = {{24{byte_sel[7]}}, byte_sel[7:0]};
      MEM_LBU: load_ext = {24'b0, byte_sel[7:0]};
      MEM_LH:  load_ext = {{16{half_sel[15]}}, half_sel[15:0]};
      MEM_LHU: load_ext = {16'b0, half_sel[15:0]};
      default: load_ext = i_axi.rdata;
    endcase
  end

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state    <= IDLE;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
      b_ready  <= 1'b0;
      ar_valid <= 1'b0;
      r_ready  <= 1'b0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        IDLE: begin
          if (i_start && start_store) begin
            aw_valid <= 1'b1;
            w_valid  <= 1'b1;
            state    <= WRITE;
          end else if (i_start) begin
            ar_valid <= 1'b1;
            state    <= READ;
          end
        end
        WRITE: begin
          // aw and w may complete on different edges
          if (i_axi.awready) begin
            aw_valid <= 1'b0;
          end
          if (i_axi.wready) begin
            w_valid <= 1'b0;
          end
          if ((!aw_valid || i_axi.awready) && (!w_valid || i_axi.wready)) begin
            b_ready <= 1'b1;
            state   <= WRESP;
          end
        end
        WRESP: begin
          if (i_axi.bvalid) begin
            b_ready <= 1'b0;
            done    <= 1'b1;
            state   <= IDLE;
          end
        end
        READ: begin
          if (i_axi.arready) begin
            ar_valid <= 1'b0;
            r_ready  <= 1'b1;
            state    <= RDATA;
          end
        end
        RDATA: begin
          if (i_axi.rvalid) begin
            r_ready <= 1'b0;
            done    <= 1'b1;
            state   <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == IDLE && i_start) begin
      addr_q  <= i_addr;
      op_q    <= i_mem_op;
      wdata_q <= st_data;
      wstrb_q <= st_strb;
    end
    if (state == RDATA && i_axi.rvalid) begin
      rdata_q <= load_ext;
    end
  end

  always_comb begin
    o_axi.awaddr  = {addr_q[XLEN-1:2], 2'b00};
    o_axi.awvalid = aw_valid;
    o_axi.wdata   = wdata_q;
    o_axi.wstrb   = wstrb_q;
    o_axi.wvalid  = w_valid;
    o_axi.bready  = b_ready;
    o_axi.araddr  = {addr_q[XLEN-1:2], 2'b00};
    o_axi.arvalid = ar_valid;
    o_axi.rready  = r_ready;
  end

  assign o_done  = done;
  assign o_rdata = rdata_q;

endmodule

// ==== exu_pkg.sv ====
package exu_pkg;

  parameter int XLEN = 32;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU
  } alu_op_e;

  // BR_NONE marks a non-branch operation
  typedef enum logic [2:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU
  } brch_op_e;

  typedef enum logic [3:0] {
    MEM_NONE,
    MEM_LB,
    MEM_LH,
    MEM_LW,
    MEM_LBU,
    MEM_LHU,
    MEM_SB,
    MEM_SH,
    MEM_SW
  } mem_op_e;

  // second alu operand source
  typedef enum logic [1:0] {
    SRC_REG,
    SRC_IMM,
    SRC_PC4,
    SRC_PCI
  } src_sel_e;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] imm;
    alu_op_e         alu_op;
    brch_op_e        brch_op;
    mem_op_e         mem_op;
    src_sel_e        src_sel;
  } exu_req_t;

  typedef struct packed {
    logic [XLEN-1:0] res;
    logic            zero;
  } exu_res_t;

  // master to slave
  typedef struct packed {
    logic [XLEN-1:0]   awaddr;
    logic              awvalid;
    logic [XLEN-1:0]   wdata;
    logic [XLEN/8-1:0] wstrb;
    logic              wvalid;
    logic              bready;
    logic [XLEN-1:0]   araddr;
    logic              arvalid;
    logic              rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic            awready;
    logic            wready;
    logic [1:0]      bresp;
    logic            bvalid;
    logic            arready;
    logic [XLEN-1:0] rdata;
    logic [1:0]      rresp;
    logic            rvalid;
  } axil_rsp_t;

endpackage

// ==== exu_stage.sv ====
`timescale 1ns/1ps

module exu_stage import exu_pkg::*; (
  input  logic            clk,
  input  logic            i_rst_n,
  input  exu_req_t        i_req,
  input  logic            i_req_valid,
  output logic            o_req_ready,
  output exu_res_t        o_res,
  output logic            o_res_valid,
  input  logic            i_res_ready,
  output logic            o_lsu_start,
  output logic [XLEN-1:0] o_lsu_addr,
  output logic [XLEN-1:0] o_lsu_wdata,
  output mem_op_e         o_lsu_op,
  input  logic            i_lsu_done,
  input  logic [XLEN-1:0] i_lsu_rdata
);

  typedef enum logic [1:0] {
    IDLE,
    MEM,
    HOLD
  } stage_state_e;

  stage_state_e    state;
  logic            accept;
  logic            lsu_start;
  mem_op_e         mem_op_q;
  logic [XLEN-1:0] res_q;
  logic [XLEN-1:0] wdata_q;
  logic [XLEN-1:0] alu_a;
  logic [XLEN-1:0] alu_b;
  alu_op_e         alu_op;
  logic [XLEN-1:0] alu_res;
  logic            alu_eq;
  logic            alu_lt;
  logic            alu_ltu;
  logic            taken;
  logic [XLEN-1:0] next_res;

  assign accept = i_req_valid && o_req_ready;

  always_comb begin
    case (i_req.src_sel)
      SRC_REG: begin
        alu_a = i_req.src1;
        alu_b = i_req.src2;
      end
      SRC_IMM: begin
        alu_a = i_req.src1;
        alu_b = i_req.imm;
      end
      SRC_PC4: begin
        alu_a = i_req.pc;
        alu_b = XLEN'(4);
      end
      default: begin
        alu_a = i_req.pc;
        alu_b = i_req.imm;
      end
    endcase
  end

  // memory ops always add to form the address
  assign alu_op = (i_req.mem_op != MEM_NONE) ? ALU_ADD : i_req.alu_op;

  exu_alu u_alu (
    .i_a   (alu_a),
    .i_b   (alu_b),
    .i_op  (alu_op),
    .o_res (alu_res),
    .o_eq  (alu_eq),
    .o_lt  (alu_lt),
    .o_ltu (alu_ltu)
  );

  always_comb begin
    case (i_req.brch_op)
      BR_BEQ:  taken = alu_eq;
      BR_BNE:  taken = !alu_eq;
      BR_BLT:  taken = alu_lt;
      BR_BGE:  taken = !alu_lt;
      BR_BLTU: taken = alu_ltu;
      BR_BGEU: taken = !alu_ltu;
      default: taken = 1'b0;
    endcase
  end

  assign next_res = (i_req.brch_op != BR_NONE) ? {{(XLEN-1){1'b0}}, taken} : alu_res;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state     <= IDLE;
      lsu_start <= 1'b0;
      mem_op_q  <= MEM_NONE;
    end else begin
      lsu_start <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) begin
            mem_op_q <= i_req.mem_op;
            if (i_req.mem_op != MEM_NONE) begin
              lsu_start <= 1'b1;
              state     <= MEM;
            end else begin
              state <= HOLD;
            end
          end
        end
        MEM: begin
          if (i_lsu_done) begin
            state <= HOLD;
          end
        end
        HOLD: begin
          if (i_res_ready) begin
            state <= IDLE;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // stores keep the address as their result
  always_ff @(posedge clk) begin
    if (accept) begin
      res_q   <= next_res;
      wdata_q <= i_req.src2;
    end else if (state == MEM && i_lsu_done &&
                 !(mem_op_q inside {MEM_SB, MEM_SH, MEM_SW})) begin
      res_q <= i_lsu_rdata;
    end
  end

  assign o_req_ready = (state == IDLE);
  assign o_res_valid = (state == HOLD);
  assign o_res.res   = res_q;
  assign o_res.zero  = (res_q == '0);
  assign o_lsu_start = lsu_start;
  assign o_lsu_addr  = res_q;
  assign o_lsu_wdata = wdata_q;
  assign o_lsu_op    = mem_op_q;

endmodule

// ==== exu_top.sv ====
`timescale 1ns/1ps

module exu_top import exu_pkg::*; #(
  parameter int FIFO_DEPTH = 4,
  parameter int MEM_WORDS  = 256
) (
  input  logic     clk,
  input  logic     i_rst_n,
  input  exu_req_t i_req,
  input  logic     i_req_valid,
  output logic     o_req_ready,
  output exu_res_t o_res,
  output logic     o_res_valid,
  input  logic     i_res_ready
);

  exu_res_t        stg_res;
  logic            stg_valid;
  logic            fifo_ready;
  logic            lsu_start;
  logic [XLEN-1:0] lsu_addr;
  logic [XLEN-1:0] lsu_wdata;
  mem_op_e         lsu_op;
  logic            lsu_done;
  logic [XLEN-1:0] lsu_rdata;
  axil_req_t       axi_req;
  axil_rsp_t       axi_rsp;

  exu_stage u_stage (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_req       (i_req),
    .i_req_valid (i_req_valid),
    .o_req_ready (o_req_ready),
    .o_res       (stg_res),
    .o_res_valid (stg_valid),
    .i_res_ready (fifo_ready),
    .o_lsu_start (lsu_start),
    .o_lsu_addr  (lsu_addr),
    .o_lsu_wdata (lsu_wdata),
    .o_lsu_op    (lsu_op),
    .i_lsu_done  (lsu_done),
    .i_lsu_rdata (lsu_rdata)
  );

  exu_lsu u_lsu (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_start  (lsu_start),
    .i_addr   (lsu_addr),
    .i_wdata  (lsu_wdata),
    .i_mem_op (lsu_op),
    .o_done   (lsu_done),
    .o_rdata  (lsu_rdata),
    .o_axi    (axi_req),
    .i_axi    (axi_rsp)
  );

  data_sram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_sram (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_axi   (axi_req),
    .o_axi   (axi_rsp)
  );

  wb_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_data  (stg_res),
    .i_valid (stg_valid),
    .o_ready (fifo_ready),
    .o_data  (o_res),
    .o_valid (o_res_valid),
    .i_ready (i_res_ready)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f compile.f --top-module tb_exu_top -o tb_exu_top
./obj_dir/tb_exu_top

// ==== tb_exu_top.sv ====
`timescale 1ns/1ps

module tb_exu_top import exu_pkg::*; ();

  localparam int FIFO_DEPTH = 4;
  localparam int MEM_WORDS  = 256;
  localparam int TIMEOUT    = 50;

  logic        clk;
  logic        i_rst_n;
  exu_req_t    req;
  logic        req_valid;
  logic        req_ready;
  exu_res_t    res;
  logic        res_valid;
  logic        res_ready;
  logic [31:0] shadow [MEM_WORDS];
  integer      seed;

  exu_top #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .MEM_WORDS  (MEM_WORDS)
  ) i_exu_top (
    .clk         (clk),
    .i_rst_n     (i_rst_n),
    .i_req       (req),
    .i_req_valid (req_valid),
    .o_req_ready (req_ready),
    .o_res       (res),
    .o_res_valid (res_valid),
    .i_res_ready (res_ready)
  );

  always #20 clk = ~clk;

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_res(input string test, input exu_res_t exp, input exu_res_t act);
    if (act.res !== exp.res) begin
      stop_run($sformatf("Error %s: res expected %h actual %h", test, exp.res, act.res));
    end
    if (act.zero !== exp.zero) begin
      stop_run($sformatf("Error %s: zero expected %b actual %b", test, exp.zero, act.zero));
    end
  endtask

  task automatic compare_ready(input string test, input int exp, input int act);
    if (act != exp) begin
      stop_run($sformatf("Error %s: accepted expected %0d actual %0d", test, exp, act));
    end
  endtask

  task automatic compare_bit(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("Error %s: expected %b actual %b", test, exp, act));
    end
  endtask

  function automatic exu_req_t make_req(input logic [31:0] pc, input logic [31:0] src1,
                                        input logic [31:0] src2, input logic [31:0] imm,
                                        input alu_op_e alu_op, input brch_op_e brch_op,
                                        input mem_op_e mem_op, input src_sel_e src_sel);
    exu_req_t r;
    r.pc      = pc;
    r.src1    = src1;
    r.src2    = src2;
    r.imm     = imm;
    r.alu_op  = alu_op;
    r.brch_op = brch_op;
    r.mem_op  = mem_op;
    r.src_sel = src_sel;
    return r;
  endfunction

  function automatic exu_req_t rand_alu_req(input alu_op_e op, input src_sel_e sel);
    logic [31:0] pc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    pc  = $random(seed);
    a   = $random(seed);
    b   = $random(seed);
    imm = $random(seed);
    return make_req(pc, a, b, imm, op, BR_NONE, MEM_NONE, sel);
  endfunction

  // expected result of one request and the shadow memory update for stores
  task automatic ref_model(input exu_req_t r, output exu_res_t exp);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] word;
    logic [31:0] lane_b;
    logic [31:0] lane_h;
    logic        taken;
    int          idx;
    int          off;
    case (r.src_sel)
      SRC_REG: begin
        a = r.src1;
        b = r.src2;
      end
      SRC_IMM: begin
        a = r.src1;
        b = r.imm;
      end
      SRC_PC4: begin
        a = r.pc;
        b = 32'd4;
      end
      default: begin
        a = r.pc;
        b = r.imm;
      end
    endcase
    addr   = r.src1 + r.imm;
    idx    = int'(addr[31:2]) % MEM_WORDS;
    off    = int'(addr[1:0]);
    word   = shadow[idx];
    lane_b = word >> (8 * off);
    lane_h = word >> (16 * (off / 2));
    taken  = 1'b0;
    exp.res = '0;
    if (r.mem_op != MEM_NONE) begin
      case (r.mem_op)
        MEM_SW: shadow[idx] = r.src2;
        MEM_SH: shadow[idx][16 * (off / 2) +: 16] = r.src2[15:0];
        MEM_SB: shadow[idx][8 * off +: 8] = r.src2[7:0];
        MEM_LW: exp.res = word;
        MEM_LH: exp.res = {{16{lane_h[15]}}, lane_h[15:0]};
        MEM_LHU: exp.res = {16'b0, lane_h[15:0]};
        MEM_LB: exp.res = {{24{lane_b[7]}}, lane_b[7:0]};
        MEM_LBU: exp.res = {24'b0, lane_b[7:0]};
        default: exp.res = '0;
      endcase
      if (r.mem_op inside {MEM_SB, MEM_SH, MEM_SW}) begin
        exp.res = addr;
      end
    end else if (r.brch_op != BR_NONE) begin
      case (r.brch_op)
        BR_BEQ:  taken = (a == b);
        BR_BNE:  taken = (a != b);
        BR_BLT:  taken = ($signed(a) < $signed(b));
        BR_BGE:  taken = ($signed(a) >= $signed(b));
        BR_BLTU: taken = (a < b);
        BR_BGEU: taken = (a >= b);
        default: taken = 1'b0;
      endcase
      exp.res = {31'b0, taken};
    end else begin
      case (r.alu_op)
        ALU_ADD:  exp.res = a + b;
        ALU_SUB:  exp.res = a - b;
        ALU_AND:  exp.res = a & b;
        ALU_OR:   exp.res = a | b;
        ALU_XOR:  exp.res = a ^ b;
        ALU_SLL:  exp.res = a << b[4:0];
        ALU_SRL:  exp.res = a >> b[4:0];
        ALU_SRA:  exp.res = $signed(a) >>> b[4:0];
        ALU_SLT:  exp.res = {31'b0, ($signed(a) < $signed(b))};
        ALU_SLTU: exp.res = {31'b0, (a < b)};
        default:  exp.res = '0;
      endcase
    end
    exp.zero = (exp.res == 32'd0);
  endtask

  // handshake sampled at the falling edge
  task automatic send_req(input exu_req_t r, output bit accepted);
    int waited;
    waited    = 0;
    req       = r;
    req_valid = 1'b1;
    @(negedge clk);
    while (!req_ready && waited < TIMEOUT) begin
      waited++;
      @(negedge clk);
    end
    accepted = req_ready;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic take_res(input string test, output exu_res_t r);
    int waited;
    waited = 0;
    @(negedge clk);
    while (!res_valid) begin
      waited++;
      if (waited > TIMEOUT) begin
        stop_run($sformatf("%s: no result came out before the timeout", test));
      end
      @(negedge clk);
    end
    r = res;
    @(posedge clk);
    #1;
  endtask

  task automatic execute_one(input string test, input exu_req_t r);
    exu_res_t exp;
    exu_res_t act;
    bit       ok;
    ref_model(r, exp);
    send_req(r, ok);
    if (!ok) begin
      stop_run($sformatf("%s: the request was not accepted before the timeout", test));
    end
    take_res(test, act);
    compare_res(test, exp, act);
  endtask

  task automatic test_reset();
    compare_bit("reset o_res_valid", 1'b0, res_valid);
    compare_bit("reset o_req_ready", 1'b1, req_ready);
  endtask

  task automatic test_alu();
    exu_req_t r;
    src_sel_e sel;
    for (int i = 0; i < 40; i++) begin
      sel = ((i / 10) % 2 == 1) ? SRC_IMM : SRC_REG;
      r   = rand_alu_req(alu_op_e'(4'(i % 10)), sel);
      // equal operands now and then to hit a zero result
      if (i % 8 == 3) begin
        r.src2 = r.src1;
        r.imm  = r.src1;
      end
      execute_one($sformatf("alu %0d %s", i, r.alu_op.name()), r);
    end
  endtask

  task automatic test_branches();
    logic [31:0] lhs [4];
    logic [31:0] rhs [4];
    logic [31:0] pc;
    brch_op_e    bop;
    lhs = '{32'h1234_5678, 32'hffff_fffb, 32'h0000_0003, 32'h0000_000a};
    rhs = '{32'h1234_5678, 32'h0000_0003, 32'hffff_fffb, 32'h0000_0014};
    pc  = $random(seed);
    execute_one("pc4", make_req(pc, $random(seed), $random(seed), $random(seed),
                                ALU_ADD, BR_NONE, MEM_NONE, SRC_PC4));
    execute_one("pci", make_req(pc, $random(seed), $random(seed), 32'hffff_ff00,
                                ALU_ADD, BR_NONE, MEM_NONE, SRC_PCI));
    for (int b = 1; b <= 6; b++) begin
      bop = brch_op_e'(3'(b));
      for (int p = 0; p < 4; p++) begin
        execute_one($sformatf("branch %s pair %0d", bop.name(), p),
                    make_req(pc, lhs[p], rhs[p], 32'd0, ALU_SUB, bop,
                             MEM_NONE, SRC_REG));
      end
    end
  endtask

  task automatic test_memory();
    logic [31:0] base;
    mem_op_e     ops [16];
    int          offs [16];
    base = 32'h0000_0100;
    execute_one("sw 0", make_req(0, base, 32'h8c7e_41f5, 0, ALU_ADD, BR_NONE, MEM_SW, SRC_IMM));
    execute_one("sw 4", make_req(0, base, 32'h1357_9bdf, 4, ALU_ADD, BR_NONE, MEM_SW, SRC_IMM));
    execute_one("sw 8", make_req(0, base, $random(seed), 8, ALU_ADD, BR_NONE, MEM_SW, SRC_IMM));
    execute_one("sh 6", make_req(0, base, 32'h3333_8a5c, 6, ALU_ADD, BR_NONE, MEM_SH, SRC_IMM));
    execute_one("sh 8", make_req(0, base, 32'h4444_7f01, 8, ALU_ADD, BR_NONE, MEM_SH, SRC_IMM));
    execute_one("sb 5", make_req(0, base, 32'h5555_55f3, 5, ALU_ADD, BR_NONE, MEM_SB, SRC_IMM));
    execute_one("sb 11", make_req(0, base, 32'h6666_6680, 11, ALU_ADD, BR_NONE, MEM_SB, SRC_IMM));
    ops  = '{MEM_LW, MEM_LW, MEM_LW, MEM_LH, MEM_LH, MEM_LH, MEM_LHU, MEM_LHU,
             MEM_LB, MEM_LB, MEM_LB, MEM_LB, MEM_LB, MEM_LB, MEM_LBU, MEM_LBU};
    offs = '{0, 4, 8, 0, 2, 6, 2, 6, 0, 1, 2, 3, 5, 11, 3, 11};
    for (int i = 0; i < 16; i++) begin
      execute_one($sformatf("load %s at %0d", ops[i].name(), offs[i]),
                  make_req(0, base, 0, offs[i], ALU_ADD, BR_NONE, ops[i], SRC_IMM));
    end
    // negative offset from a higher base
    execute_one("lw negative imm", make_req(0, base + 32'd16, 0, 32'hffff_fff4, ALU_ADD,
                                            BR_NONE, MEM_LW, SRC_IMM));
  endtask

  task automatic test_backpressure();
    exu_res_t expq [$];
    exu_res_t exp;
    exu_res_t act;
    exu_req_t r;
    bit       ok;
    bit       stalled;
    int       accepted;
    stalled   = 1'b0;
    accepted  = 0;
    res_ready = 1'b0;
    for (int i = 0; i < FIFO_DEPTH + 2 && !stalled; i++) begin
      r = rand_alu_req(alu_op_e'(4'(i % 10)), SRC_REG);
      ref_model(r, exp);
      send_req(r, ok);
      if (ok) begin
        accepted++;
        expq.push_back(exp);
      end else begin
        stalled = 1'b1;
      end
    end
    compare_ready("backpressure", FIFO_DEPTH + 1, accepted);
    res_ready = 1'b1;
    while (expq.size() > 0) begin
      take_res("backpressure drain", act);
      compare_res("backpressure drain", expq.pop_front(), act);
    end
  endtask

  initial begin
    clk       = 1'b0;
    i_rst_n   = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    res_ready = 1'b1;
    seed      = 32'h9937_d5f8;
    repeat (4) @(posedge clk);
    #1;
    i_rst_n = 1'b1;
    test_reset();
    test_alu();
    test_branches();
    test_memory();
    test_backpressure();
    $display("test passed");
    $finish;
  end

endmodule

// ==== wb_fifo.sv ====
`timescale 1ns/1ps

module wb_fifo import exu_pkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic     clk,
  input  logic     i_rst_n,
  input  exu_res_t i_data,
  input  logic     i_valid,
  output logic     o_ready,
  output exu_res_t o_data,
  output logic     o_valid,
  input  logic     i_ready
);

  localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CW = $clog2(FIFO_DEPTH + 1);

  exu_res_t      mem [FIFO_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] count;
  logic          push;
  logic          pop;

  // full but popping still frees a slot this cycle
  assign o_ready = (count < CW'(FIFO_DEPTH)) || i_ready;
  assign o_valid = (count != '0);
  assign o_data  = mem[rd_ptr];
  assign push    = i_valid && o_ready;
  assign pop     = o_valid && i_ready;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= i_data;
    end
  end

endmodule
